// ==== verilog/periph_macros.svh ====
// Fixed address map and reset values of the peripheral register front end
// Include wherever a slot, offset or size code is decoded

`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// Read and write size code for no access
`define ACCESS_NONE       2'b11

// Region and slot fields of the 11-bit address
`define ADDR_SIMPLE_BIT   10          // Set for the byte-wide region
`define USER_SLOT_BITS    9:6         // 64 bytes per full slot
`define SIMPLE_SLOT_BITS  7:4         // 16 bytes per byte slot
`define USER_OFS_BITS     5:0
`define SIMPLE_OFS_BITS   3:0

`define SLOT_GPIO         4'd1
`define SLOT_SCRATCH      4'd15

// GPIO register offsets
`define GPIO_OUT_OFS      6'h00
`define GPIO_IN_OFS       6'h04
`define GPIO_SEL_OFS      6'h20       // Plus 4 * pin number

`define FUNC_SEL_RESET    5'd1        // Every pin starts on the GPIO slot
`define SCRATCH_REGS      4

`endif

// ==== verilog/periph_pkg.sv ====
// Shared types of the peripheral register front end
// Import into any module that handles requests, slot responses or pins

`default_nettype none

package periph_pkg;

    typedef logic [10:0] addr_t;      // Peripheral address from the core
    typedef logic [31:0] word_t;      // Bus data word
    typedef logic [7:0]  byte_t;      // Byte peripheral data
    typedef logic [7:0]  pins_t;      // Eight output or input pins
    typedef logic [1:0]  access_t;    // 00 byte, 01 half, 10 word, 11 none

    // Pin source, bit 4 picks the byte region, bits 3:0 the slot
    typedef logic [4:0]  func_sel_t;

    // One core access as seen by the peripherals
    typedef struct packed {
        addr_t   addr;
        word_t   data;
        access_t write_n;
        access_t read_n;
    } periph_req_t;

    // Read response of one slot
    typedef struct packed {
        word_t data;
        logic  ready;
    } slot_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/periph_read_capture.sv ====
// Registered read data stage between the slot response mux and the core
// Holds the captured word until the core signals read complete

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_read_capture (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire periph_pkg::periph_req_t  i_req,
    input  wire periph_pkg::slot_rsp_t    i_rsp,
    input  wire logic                     i_read_complete,
    output periph_pkg::access_t           o_read_n_masked,
    output periph_pkg::word_t             o_data_out,
    output logic                          o_data_ready
);
    import periph_pkg::*;

    logic  read_req;
    logic  capture;
    logic  hold;                                          // Word held for the core
    logic  ready_r;
    word_t data_r;

    assign read_req = i_req.read_n != `ACCESS_NONE;
    assign capture  = !hold && i_rsp.ready && read_req;

    // No second read reaches the slots while the result is buffered
    assign o_read_n_masked = i_req.read_n | {2{ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;
            ready_r <= read_req && i_rsp.ready;              // One cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= i_rsp.data;
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || (i_req.write_n != `ACCESS_NONE);  // Writes answer at once

endmodule

`default_nettype wire

// ==== verilog/periph_addr_decode.sv ====
// Slot decode and read response mux for the full and byte regions
// Purely combinational, sits between the request and the capture stage

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_addr_decode (
    input  wire periph_pkg::periph_req_t  i_req,
    input  wire periph_pkg::access_t      i_read_n_masked,
    output logic                          o_gpio_sel,
    output logic                          o_scratch_sel,
    input  wire periph_pkg::slot_rsp_t    i_gpio_rsp,
    input  wire periph_pkg::slot_rsp_t    i_scratch_rsp,
    output periph_pkg::slot_rsp_t         o_rsp
);
    import periph_pkg::*;

    logic       simple_region;
    logic       access;
    logic [3:0] user_slot;
    logic [3:0] simple_slot;

    always_comb begin
        simple_region = i_req.addr[`ADDR_SIMPLE_BIT];
        user_slot     = i_req.addr[`USER_SLOT_BITS];
        simple_slot   = i_req.addr[`SIMPLE_SLOT_BITS];

        // A slot is only strobed while some access is present
        access = (i_req.write_n != `ACCESS_NONE) || (i_read_n_masked != `ACCESS_NONE);

        o_gpio_sel    = access && !simple_region && (user_slot == `SLOT_GPIO);
        o_scratch_sel = access && simple_region && (simple_slot == `SLOT_SCRATCH);

        // Empty slots read zero and answer ready
        o_rsp = '{data: '0, ready: 1'b1};
        if (simple_region) begin
            if (simple_slot == `SLOT_SCRATCH) begin
                o_rsp.data  = {24'h0, i_scratch_rsp.data[7:0]};   // Byte data only
                o_rsp.ready = i_scratch_rsp.ready;
            end
        end else if (user_slot == `SLOT_GPIO) begin
            o_rsp = i_gpio_rsp;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gpio_block.sv ====
// GPIO slot: output register, input pin readback and per-pin output routing
// Each output pin takes its bit from the slot named by its selector

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module gpio_block (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     i_sel,
    input  wire periph_pkg::periph_req_t  i_req,
    input  wire periph_pkg::pins_t        i_ui_in,
    input  wire periph_pkg::pins_t        i_scratch_pins,
    output periph_pkg::slot_rsp_t         o_rsp,
    output periph_pkg::pins_t             o_uo_out
);
    import periph_pkg::*;

    logic [5:0] ofs;
    logic       wr;
    logic       sel_window;
    pins_t      gpio_out;
    func_sel_t  func_sel [8];

    assign ofs = i_req.addr[`USER_OFS_BITS];
    assign wr  = i_sel && (i_req.write_n != `ACCESS_NONE);

    // Selectors live at 0x20..0x3c, word aligned
    assign sel_window = ofs[5] && (ofs[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr && ofs == `GPIO_OUT_OFS) begin
            gpio_out <= i_req.data[7:0];
        end
    end

    for (genvar i = 0; i < 8; i++) begin : g_pin
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                func_sel[i] <= `FUNC_SEL_RESET;
            end else if (wr && ofs == 6'(`GPIO_SEL_OFS + 4 * i)) begin
                func_sel[i] <= i_req.data[4:0];
            end
        end

        // Only GPIO and the scratch slot have pins, any other source is low
        assign o_uo_out[i] = func_sel[i][4]
            ? ((func_sel[i][3:0] == `SLOT_SCRATCH) && i_scratch_pins[i])
            : ((func_sel[i][3:0] == `SLOT_GPIO) && gpio_out[i]);
    end

    always_comb begin
        o_rsp.ready = 1'b1;                                  // Registers answer at once
        o_rsp.data  = '0;
        if (ofs == `GPIO_OUT_OFS) begin
            o_rsp.data[7:0] = gpio_out;
        end else if (ofs == `GPIO_IN_OFS) begin
            o_rsp.data[7:0] = i_ui_in;
        end else if (sel_window) begin
            o_rsp.data[4:0] = func_sel[ofs[4:2]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/byte_scratch.sv ====
// Byte slot with four read/write scratch registers
// Register 0 is also presented on the slot's eight pins

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module byte_scratch (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     i_sel,
    input  wire periph_pkg::periph_req_t  i_req,
    output periph_pkg::slot_rsp_t         o_rsp,
    output periph_pkg::pins_t             o_pins
);
    import periph_pkg::*;

    logic [3:0] ofs;
    logic       wr;
    logic       in_range;                                    // Offset names a register
    byte_t      regs [`SCRATCH_REGS];

    assign ofs      = i_req.addr[`SIMPLE_OFS_BITS];
    assign wr       = i_sel && (i_req.write_n != `ACCESS_NONE);
    assign in_range = ofs < `SCRATCH_REGS;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `SCRATCH_REGS; k++) regs[k] <= '0;
        end else if (wr && in_range) begin
            regs[ofs[1:0]] <= i_req.data[7:0];               // Low byte only
        end
    end

    assign o_rsp.data  = in_range ? {24'h0, regs[ofs[1:0]]} : '0;
    assign o_rsp.ready = 1'b1;
    assign o_pins      = regs[0];

endmodule

`default_nettype wire

// ==== verilog/periph_top.sv ====
// Peripheral register front end as seen by the core
// Decode, read capture, GPIO slot and the byte scratch slot

`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire periph_pkg::pins_t    i_ui_in,
    input  wire periph_pkg::addr_t    i_addr,
    input  wire periph_pkg::word_t    i_data,
    input  wire periph_pkg::access_t  i_write_n,
    input  wire periph_pkg::access_t  i_read_n,
    input  wire logic                 i_read_complete,
    output periph_pkg::word_t         o_data_out,
    output logic                      o_data_ready,
    output periph_pkg::pins_t         o_uo_out
);
    import periph_pkg::*;

    periph_req_t req;
    periph_req_t slot_req;                                   // Read size masked while buffering
    access_t     read_n_masked;
    logic        gpio_sel;
    logic        scratch_sel;
    slot_rsp_t   gpio_rsp;
    slot_rsp_t   scratch_rsp;
    slot_rsp_t   sel_rsp;
    pins_t       scratch_pins;

    assign req      = '{addr: i_addr, data: i_data, write_n: i_write_n, read_n: i_read_n};
    assign slot_req = '{addr: i_addr, data: i_data, write_n: i_write_n, read_n: read_n_masked};

    periph_addr_decode u_decode (
        .i_req           (req),
        .i_read_n_masked (read_n_masked),
        .o_gpio_sel      (gpio_sel),
        .o_scratch_sel   (scratch_sel),
        .i_gpio_rsp      (gpio_rsp),
        .i_scratch_rsp   (scratch_rsp),
        .o_rsp           (sel_rsp)
    );

    periph_read_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_rsp           (sel_rsp),
        .i_read_complete (i_read_complete),
        .o_read_n_masked (read_n_masked),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    gpio_block u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_sel          (gpio_sel),
        .i_req          (slot_req),
        .i_ui_in        (i_ui_in),
        .i_scratch_pins (scratch_pins),
        .o_rsp          (gpio_rsp),
        .o_uo_out       (o_uo_out)
    );

    byte_scratch u_scratch (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_sel  (scratch_sel),
        .i_req  (slot_req),
        .o_rsp  (scratch_rsp),
        .o_pins (scratch_pins)
    );

endmodule

`default_nettype wire

// ==== test/periph_checker.sv ====
// Watches the ports of the peripheral front end and compares them with a shadow model
// Instantiated beside the DUT in the testbench, which reads its error count

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module periph_checker (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire periph_pkg::pins_t    i_ui_in,
    input  wire periph_pkg::addr_t    i_addr,
    input  wire periph_pkg::word_t    i_data,
    input  wire periph_pkg::access_t  i_write_n,
    input  wire periph_pkg::access_t  i_read_n,
    input  wire logic                 i_read_complete,
    input  wire periph_pkg::word_t    i_data_out,
    input  wire logic                 i_data_ready,
    input  wire periph_pkg::pins_t    i_uo_out,
    output int                        o_errors
);
    import periph_pkg::*;

    periph_req_t req;
    pins_t       gpio_sh;
    func_sel_t   sel_sh [8];
    byte_t       scratch_sh [`SCRATCH_REGS];
    logic        rd_wait;                                    // Ready is due next cycle
    logic        rd_hold;
    word_t       rd_exp;

    assign req = '{addr: i_addr, data: i_data, write_n: i_write_n, read_n: i_read_n};

    // Expected read word from the address map and the shadow registers
    function automatic word_t expected_read(input addr_t a, input pins_t ui);
        logic [5:0] ofs;
        ofs = a[5:0];
        if (a[10])
            return (a[7:4] == 4'd15 && a[3:0] < 4'd4) ? {24'h0, scratch_sh[a[1:0]]} : 32'h0;
        if (a[9:6] != 4'd1) return 32'h0;
        if (ofs == 6'h00) return {24'h0, gpio_sh};
        if (ofs == 6'h04) return {24'h0, ui};
        if (ofs[5] && ofs[1:0] == 2'b00) return {27'h0, sel_sh[ofs[4:2]]};
        return 32'h0;
    endfunction

    function automatic pins_t expected_pins();
        pins_t p;
        for (int i = 0; i < 8; i++) begin
            if (sel_sh[i][4]) p[i] = (sel_sh[i][3:0] == 4'd15) && scratch_sh[0][i];
            else p[i] = (sel_sh[i][3:0] == 4'd1) && gpio_sh[i];
        end
        return p;
    endfunction

    task automatic apply_write(input periph_req_t r);
        if (r.addr[10]) begin
            if (r.addr[7:4] == 4'd15 && r.addr[3:0] < 4'd4) scratch_sh[r.addr[1:0]] = r.data[7:0];
        end else if (r.addr[9:6] == 4'd1) begin
            if (r.addr[5:0] == 6'h00) gpio_sh = r.data[7:0];
            for (int i = 0; i < 8; i++) begin
                if (r.addr[5:0] == 6'h20 + 6'(4 * i)) sel_sh[i] = r.data[4:0];
            end
        end
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error %s expected %h actual %h at %0t", name, exp, act, $time);
            o_errors++;
        end
    endtask

    // Inputs change just after the rising edge, so the falling edge sees settled values
    always @(negedge clk) begin
        if (!rst_n) begin
            gpio_sh = '0;
            for (int i = 0; i < 8; i++) sel_sh[i] = `FUNC_SEL_RESET;
            for (int k = 0; k < `SCRATCH_REGS; k++) scratch_sh[k] = '0;
            rd_wait  = 1'b0;
            rd_hold  = 1'b0;
            rd_exp   = '0;
            o_errors = 0;
        end else begin
            check_value("o_uo_out", 32'(expected_pins()), 32'(i_uo_out));
            if (req.write_n != `ACCESS_NONE)
                check_value("o_data_ready", 32'd1, 32'(i_data_ready));   // Same-cycle answer
            else if (req.read_n == `ACCESS_NONE && !rd_wait && !rd_hold)
                check_value("o_data_ready", 32'd0, 32'(i_data_ready));

            if (rd_wait) begin
                if (!i_data_ready) begin
                    $display("Read of address %h was not answered one cycle after the request",
                             req.addr);
                    o_errors++;
                end else begin
                    check_value("o_data_out", rd_exp, i_data_out);
                end
                rd_wait = 1'b0;
                rd_hold = i_data_ready && !i_read_complete;
            end else if (rd_hold) begin
                if (!i_data_ready) begin
                    $display("Ready of the read of address %h dropped before read complete",
                             req.addr);
                    o_errors++;
                    rd_hold = 1'b0;
                end else begin
                    check_value("o_data_out", rd_exp, i_data_out);  // Held word
                    if (i_read_complete) rd_hold = 1'b0;            // Ready must drop next cycle
                end
            end

            if (!rd_wait && !rd_hold && req.read_n != `ACCESS_NONE) begin
                if (i_data_ready) begin
                    $display("Read of address %h was answered in its first cycle, one too early",
                             req.addr);
                    o_errors++;
                end
                rd_exp  = expected_read(req.addr, i_ui_in);
                rd_wait = 1'b1;
            end

            // Registers change at the next edge, so pins are compared first
            if (req.write_n != `ACCESS_NONE) apply_write(req);
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
// Top-level testbench of the peripheral register front end
// Runs numbered access sequences on periph_top while periph_checker compares

`timescale 1ns/1ps
`default_nettype none

`include "periph_macros.svh"

module tb_top;
    import periph_pkg::*;

    localparam int NUM_ACCESSES = 8 + 8 + 4 + 12 + 15 + 3;       // Summed over the six tests
    localparam int CLK_PERIOD   = 8;
    localparam int WATCHDOG_NS  = 2 * NUM_ACCESSES * 10 * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    pins_t   ui_in;
    addr_t   addr;
    word_t   data;
    access_t write_n;
    access_t read_n;
    logic    read_complete;
    word_t   data_out;
    logic    data_ready;
    pins_t   uo_out;
    int      chk_errors;
    int      tb_errors;
    int      err_base;
    int      test_num;
    int      tests_passed;
    int      tests_failed;

    periph_top dut0 (
        .clk (clk), .rst_n (rst_n), .i_ui_in (ui_in), .i_addr (addr), .i_data (data),
        .i_write_n (write_n), .i_read_n (read_n), .i_read_complete (read_complete),
        .o_data_out (data_out), .o_data_ready (data_ready), .o_uo_out (uo_out)
    );

    periph_checker u_checker (
        .clk (clk), .rst_n (rst_n), .i_ui_in (ui_in), .i_addr (addr), .i_data (data),
        .i_write_n (write_n), .i_read_n (read_n), .i_read_complete (read_complete),
        .i_data_out (data_out), .i_data_ready (data_ready), .i_uo_out (uo_out),
        .o_errors (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic addr_t full_addr(input logic [3:0] slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic addr_t byte_addr(input logic [3:0] slot, input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    function automatic addr_t sel_addr(input int pin);
        return full_addr(`SLOT_GPIO, 6'(`GPIO_SEL_OFS + 4 * pin));
    endfunction

    task automatic write_reg(input addr_t a, input word_t d);
        addr    = a;
        data    = d;
        write_n = 2'b10;                                     // Word write
        @(posedge clk);
        #1;
        write_n = `ACCESS_NONE;
    endtask

    // Holds the read until ready, then keeps it hold_cycles longer with moving pins
    task automatic read_reg(input addr_t a, input int hold_cycles);
        int n;
        addr   = a;
        read_n = 2'b10;
        n      = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!data_ready && n < 10);
        if (!data_ready) begin
            $display("Read of address %h got no ready within 10 cycles", a);
            tb_errors++;
        end
        repeat (hold_cycles) begin
            ui_in = pins_t'($urandom);
            @(posedge clk);
            #1;
        end
        read_n        = `ACCESS_NONE;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic begin_test();
        test_num++;
        err_base = chk_errors + tb_errors;
    endtask

    task automatic end_test(input string name);
        int errs;
        @(posedge clk);                                      // Let the last pin update be seen
        #1;
        errs = chk_errors + tb_errors - err_base;
        if (errs == 0) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_num, name, errs);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        data          = '0;
        write_n       = `ACCESS_NONE;
        read_n        = `ACCESS_NONE;
        read_complete = 1'b0;
        tb_errors     = 0;
        test_num      = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        void'($urandom(32'hc60ee44c));
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        begin_test();
        for (int i = 0; i < 8; i++) read_reg(sel_addr(i), 0);
        end_test("reset values");

        begin_test();
        repeat (4) begin
            write_reg(full_addr(`SLOT_GPIO, `GPIO_OUT_OFS), $urandom);
            read_reg(full_addr(`SLOT_GPIO, `GPIO_OUT_OFS), 0);
        end
        end_test("gpio output");

        begin_test();
        repeat (4) begin
            ui_in = pins_t'($urandom);
            read_reg(full_addr(`SLOT_GPIO, `GPIO_IN_OFS), 0);
        end
        end_test("gpio input");

        begin_test();
        write_reg(full_addr(`SLOT_GPIO, `GPIO_OUT_OFS), 32'hff);     // Empty sources must win
        write_reg(byte_addr(`SLOT_SCRATCH, 4'd0), $urandom);
        for (int i = 0; i < 4; i++) write_reg(sel_addr(i), 32'({1'b1, `SLOT_SCRATCH}));
        for (int i = 4; i < 8; i++) write_reg(sel_addr(i), (i % 2 == 0) ? 32'h03 : 32'h12);
        write_reg(byte_addr(`SLOT_SCRATCH, 4'd0), $urandom);
        write_reg(byte_addr(`SLOT_SCRATCH, 4'd0), $urandom);
        end_test("pin routing");

        begin_test();
        for (int k = 0; k < `SCRATCH_REGS; k++) begin
            write_reg(byte_addr(`SLOT_SCRATCH, 4'(k)), $urandom);
        end
        for (int k = 0; k < `SCRATCH_REGS; k++) read_reg(byte_addr(`SLOT_SCRATCH, 4'(k)), 0);
        read_reg(byte_addr(`SLOT_SCRATCH, 4'd4), 0);
        read_reg(byte_addr(`SLOT_SCRATCH, 4'd9), 0);
        read_reg(byte_addr(`SLOT_SCRATCH, 4'd15), 0);
        read_reg(byte_addr(4'd3, 4'd0), 0);
        read_reg(full_addr(4'd0, 6'h00), 0);
        read_reg(full_addr(4'd5, 6'h00), 0);
        read_reg(full_addr(4'd15, 6'h04), 0);
        end_test("scratch and empty slots");

        begin_test();
        write_reg(full_addr(`SLOT_GPIO, `GPIO_OUT_OFS), $urandom);
        read_reg(full_addr(`SLOT_GPIO, `GPIO_IN_OFS), 5);
        read_reg(byte_addr(`SLOT_SCRATCH, 4'd1), 3);
        end_test("handshake timing");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/periph_pkg.sv
verilog/periph_read_capture.sv
verilog/periph_addr_decode.sv
verilog/gpio_block.sv
verilog/byte_scratch.sv
verilog/periph_top.sv
test/periph_checker.sv
test/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the peripheral front end testbench

TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
